//--- list.f
+incdir+logic
logic/cpu_pkg.sv
logic/ctrl_if.sv
logic/microcode.sv
logic/control_logic.sv
logic/reg_file.sv
logic/mlu.sv
logic/datapath.sv
logic/mmu.sv
logic/cpu_top.sv
tb/cpu_tb.sv

//--- logic/control_logic.sv
`default_nettype none

`include "cpu_config.svh"

module control_logic (
  input  logic            clk,
  input  logic            rst_n,
  input  cpu_pkg::word_t  bus,
  input  cpu_pkg::word_t  opword,
  input  logic            flag_zero,
  input  logic            flag_carry,
  input  logic            flag_negative,
  ctrl_if.ctrl            cw,
  output cpu_pkg::uaddr_t uaddr
);

  cpu_pkg::opcode_t opcode;       // Current routine.
  cpu_pkg::opcode_t opcode_next;
  cpu_pkg::ucount_t ucount;       // Step within the routine.
  logic             cond;         // Condition seen by the next step.
  logic             cond_next;

  always_comb begin
    case (cw.cond_sel)
      cpu_pkg::COND_ZERO:     cond_next = flag_zero;
      cpu_pkg::COND_CARRY:    cond_next = flag_carry;
      cpu_pkg::COND_NEGATIVE: cond_next = flag_negative;
      default:                cond_next = 1'b0;  // No interrupt source.
    endcase
  end

  assign opcode_next = cw.opcode_sel
      ? cpu_pkg::opcode_t'(bus[`CPU_OPCODE_W-1:0])                     // Fetch literal.
      : cpu_pkg::opcode_t'(opword[`CPU_WORD_W-1 -: `CPU_OPCODE_W]);  // Decoded op.

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      opcode <= cpu_pkg::OP_RESET;
      ucount <= '0;
      cond   <= 1'b0;
    end else begin
      cond   <= cond_next;
      ucount <= cw.reset_ucount ? '0 : ucount + cpu_pkg::ucount_t'(1);
      if (cw.in_plane == cpu_pkg::IN_OPCODE) begin
        opcode <= opcode_next;
      end
    end
  end

  assign uaddr = {cond, opcode, ucount};

  // Longest routine is the taken BEQ.
  a_ucount_max: assert property (@(posedge clk) disable iff (!rst_n)
      ucount <= cpu_pkg::ucount_t'(8))
    else $error("control_logic: micro-op counter ran past 8");

  // The bus must carry the ROM literal when the opcode comes from it.
  a_opcode_literal: assert property (@(posedge clk) disable iff (!rst_n)
      (cw.in_plane == cpu_pkg::IN_OPCODE && cw.opcode_sel)
      |-> bus[`CPU_CTRL_DATA_W-1:0] == cw.ctrl_data)
    else $error("control_logic: bus does not carry the opcode literal");

endmodule

`default_nettype wire

//--- logic/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath sizing.
`define CPU_WORD_W 32          // Bus and register width.
`define CPU_NUM_REGS 32        // General registers.
`define CPU_REG_IDX_W 5        // Register index width.
`define CPU_REG_PC 31          // r31 is the program counter.

// Memory sizing.
`define CPU_MEM_WORDS 256      // Word depth of the MMU array.
`define CPU_MEM_ADDR_W 10      // Byte address width on load/store ports.

// Microcode address fields.
`define CPU_UADDR_W 12         // Condition, opcode and counter.
`define CPU_OPCODE_W 6         // Opcode field.
`define CPU_UCOUNT_W 5         // Micro-op counter field.
`define CPU_CTRL_DATA_W 6      // Literal in the control word.

`endif

//--- logic/cpu_pkg.sv
`default_nettype none

`include "cpu_config.svh"

package cpu_pkg;

  typedef logic [`CPU_WORD_W-1:0]      word_t;       // Bus word.
  typedef logic [`CPU_REG_IDX_W-1:0]   reg_idx_t;    // Register index.
  typedef logic [`CPU_UCOUNT_W-1:0]    ucount_t;     // Micro-op count.
  typedef logic [`CPU_UADDR_W-1:0]     uaddr_t;      // Microcode address.
  typedef logic [`CPU_CTRL_DATA_W-1:0] ctrl_data_t;  // Control literal.
  typedef logic [`CPU_MEM_ADDR_W-1:0]  mem_addr_t;   // Byte address.

  typedef enum logic [`CPU_OPCODE_W-1:0] {
    OP_RESET = 6'd0,
    OP_FETCH = 6'd1,
    OP_LHU   = 6'd2,  // rD = zeroext(I).
    OP_ADDU  = 6'd3,  // rD = rS + zeroext(I).
    OP_ADD3  = 6'd4,  // rD = rA + rB.
    OP_SW    = 6'd5,  // mem[rD] = rS.
    OP_OR3   = 6'd6,  // rD = rA | rB.
    OP_LH    = 6'd7,  // rD = signext(I).
    OP_BEQ   = 6'd8,  // Branch relative when rA == rB.
    OP_LW    = 6'd9   // rD = mem[rS].
  } opcode_t;

  typedef enum logic [1:0] {
    REG_SEL_OPWORD0, REG_SEL_OPWORD1, REG_SEL_OPWORD2, REG_SEL_CONTROL
  } reg_sel_t;

  typedef enum logic [3:0] {
    OUT_NONE = 4'd0, OUT_REG = 4'd1, OUT_TMP0 = 4'd2, OUT_TMP1 = 4'd3,
    OUT_MMU = 4'd4, OUT_MLU = 4'd5, OUT_SHIFTER = 4'd6,
    OUT_CTRL_DATA = 4'd8, OUT_OPWORD_IMM = 4'd9  // 7 was the timer.
  } out_plane_t;

  typedef enum logic [2:0] {
    IN_NONE, IN_REG, IN_TMP0, IN_TMP1, IN_MMU, IN_OPWORD, IN_OPCODE
  } in_plane_t;

  typedef enum logic [2:0] {MLU_ADD, MLU_SUB, MLU_OR} mlu_op_t;

  typedef enum logic [1:0] {SHIFT_PASS, SHIFT_SIGNEXT16} shifter_plane_t;

  typedef enum logic [1:0] {
    COND_ZERO, COND_CARRY, COND_NEGATIVE, COND_INTERRUPT
  } cond_sel_t;

endpackage

`default_nettype wire

//--- logic/cpu_top.sv
`default_nettype none

`include "cpu_config.svh"

module cpu_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               load_we,
  input  cpu_pkg::mem_addr_t load_addr,
  input  cpu_pkg::word_t     load_data,
  output logic               store_we,
  output cpu_pkg::mem_addr_t store_addr,
  output cpu_pkg::word_t     store_data
);

  ctrl_if cw ();

  cpu_pkg::uaddr_t uaddr;
  cpu_pkg::word_t  bus;
  cpu_pkg::word_t  opword;
  cpu_pkg::word_t  tmp0;
  cpu_pkg::word_t  reg_rdata;
  cpu_pkg::word_t  mem_rdata;
  logic            flag_zero;
  logic            flag_carry;
  logic            flag_negative;

  microcode u_microcode (.uaddr(uaddr), .cw(cw.rom));

  control_logic u_control_logic (
    .clk(clk), .rst_n(rst_n), .bus(bus), .opword(opword),
    .flag_zero(flag_zero), .flag_carry(flag_carry), .flag_negative(flag_negative),
    .cw(cw.ctrl), .uaddr(uaddr)
  );

  reg_file u_reg_file (
    .clk(clk), .rst_n(rst_n), .cw(cw.dp), .opword(opword), .bus(bus),
    .reg_rdata(reg_rdata)
  );

  datapath u_datapath (
    .clk(clk), .rst_n(rst_n), .cw(cw.dp), .reg_rdata(reg_rdata), .mem_rdata(mem_rdata),
    .bus(bus), .opword(opword), .tmp0(tmp0),
    .flag_zero(flag_zero), .flag_carry(flag_carry), .flag_negative(flag_negative)
  );

  mmu u_mmu (
    .clk(clk), .rst_n(rst_n), .cw(cw.dp), .tmp0(tmp0), .bus(bus), .mem_rdata(mem_rdata),
    .load_we(load_we), .load_addr(load_addr), .load_data(load_data), .store_we(store_we)
  );

  assign store_addr = tmp0[`CPU_MEM_ADDR_W-1:0];  // Store observed at the MMU address.
  assign store_data = bus;

endmodule

`default_nettype wire

//--- logic/ctrl_if.sv
`default_nettype none

interface ctrl_if;
  cpu_pkg::ctrl_data_t     ctrl_data;      // Literal for bus or register select.
  cpu_pkg::reg_sel_t       reg_sel;        // Register index source.
  cpu_pkg::out_plane_t     out_plane;      // Bus driver.
  cpu_pkg::in_plane_t      in_plane;       // Bus loader.
  logic                    reset_ucount;   // Ends the routine.
  cpu_pkg::mlu_op_t        mlu_op;
  logic                    mlu_carry;      // Carry into the MLU adder.
  cpu_pkg::shifter_plane_t shifter_plane;
  logic                    opcode_sel;     // 1 takes the opcode from the bus.
  cpu_pkg::cond_sel_t      cond_sel;       // Flag latched for the next step.

  modport rom (output ctrl_data, reg_sel, out_plane, in_plane, reset_ucount, mlu_op,
               mlu_carry, shifter_plane, opcode_sel, cond_sel);
  modport ctrl (input ctrl_data, in_plane, reset_ucount, opcode_sel, cond_sel);
  modport dp (input reg_sel, out_plane, in_plane, mlu_op, mlu_carry, shifter_plane,
              ctrl_data);
endinterface

`default_nettype wire

//--- logic/datapath.sv
`default_nettype none

`include "cpu_config.svh"

module datapath (
  input  logic           clk,
  input  logic           rst_n,
  ctrl_if.dp             cw,
  input  cpu_pkg::word_t reg_rdata,
  input  cpu_pkg::word_t mem_rdata,
  output cpu_pkg::word_t bus,
  output cpu_pkg::word_t opword,
  output cpu_pkg::word_t tmp0,
  output logic           flag_zero,
  output logic           flag_carry,
  output logic           flag_negative
);

  cpu_pkg::word_t tmp1;
  cpu_pkg::word_t mlu_result;
  cpu_pkg::word_t shifter_out;

  mlu u_mlu (
    .op           (cw.mlu_op),
    .carry_in     (cw.mlu_carry),
    .a            (tmp0),
    .b            (tmp1),
    .result       (mlu_result),
    .flag_zero    (flag_zero),
    .flag_carry   (flag_carry),
    .flag_negative(flag_negative)
  );

  assign shifter_out = (cw.shifter_plane == cpu_pkg::SHIFT_SIGNEXT16)
      ? {{(`CPU_WORD_W-16){tmp0[15]}}, tmp0[15:0]}  // Sign extend from bit 15.
      : tmp0;

  always_comb begin
    case (cw.out_plane)
      cpu_pkg::OUT_REG:        bus = reg_rdata;
      cpu_pkg::OUT_TMP0:       bus = tmp0;
      cpu_pkg::OUT_TMP1:       bus = tmp1;
      cpu_pkg::OUT_MMU:        bus = mem_rdata;
      cpu_pkg::OUT_MLU:        bus = mlu_result;
      cpu_pkg::OUT_SHIFTER:    bus = shifter_out;
      cpu_pkg::OUT_CTRL_DATA:  bus = cpu_pkg::word_t'(cw.ctrl_data);  // Zero extended.
      cpu_pkg::OUT_OPWORD_IMM: bus = cpu_pkg::word_t'(opword[15:0]);  // Zero extended.
      default:                 bus = '0;                             // Idle bus reads zero.
    endcase
  end

  // Opword feeds decode, so it starts clean.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      opword <= '0;
    end else if (cw.in_plane == cpu_pkg::IN_OPWORD) begin
      opword <= bus;
    end
  end

  always_ff @(posedge clk) begin
    if (cw.in_plane == cpu_pkg::IN_TMP0) begin
      tmp0 <= bus;
    end
    if (cw.in_plane == cpu_pkg::IN_TMP1) begin
      tmp1 <= bus;
    end
  end

endmodule

`default_nettype wire

//--- logic/microcode.sv
`default_nettype none

`include "cpu_config.svh"

module microcode (
  input  cpu_pkg::uaddr_t uaddr,
  ctrl_if.rom             cw
);

  localparam cpu_pkg::ctrl_data_t PC_SEL = cpu_pkg::ctrl_data_t'(`CPU_REG_PC);

  logic              cond;      // Latched condition.
  cpu_pkg::opcode_t  opcode;
  cpu_pkg::ucount_t  ucount;
  logic              go_fetch;  // Shared return step.

  assign cond   = uaddr[`CPU_UADDR_W-1];
  assign opcode = cpu_pkg::opcode_t'(uaddr[`CPU_UADDR_W-2:`CPU_UCOUNT_W]);
  assign ucount = uaddr[`CPU_UCOUNT_W-1:0];

  always_comb begin
    cw.ctrl_data     = '0;                        // All fields idle by default.
    cw.reg_sel       = cpu_pkg::REG_SEL_OPWORD0;
    cw.out_plane     = cpu_pkg::OUT_NONE;
    cw.in_plane      = cpu_pkg::IN_NONE;
    cw.reset_ucount  = 1'b0;
    cw.mlu_op        = cpu_pkg::MLU_ADD;
    cw.mlu_carry     = 1'b0;
    cw.shifter_plane = cpu_pkg::SHIFT_PASS;
    cw.opcode_sel    = 1'b0;
    cw.cond_sel      = cpu_pkg::COND_ZERO;
    go_fetch         = 1'b0;
    case (opcode)
      cpu_pkg::OP_RESET: begin
        case (ucount)
          5'd0: begin                             // Bus idles at zero, PC cleared.
            cw.ctrl_data = PC_SEL;
            cw.reg_sel   = cpu_pkg::REG_SEL_CONTROL;
            cw.in_plane  = cpu_pkg::IN_REG;
          end
          default: go_fetch = 1'b1;
        endcase
      end
      cpu_pkg::OP_FETCH: begin
        case (ucount)
          5'd0: begin                             // PC to TMP0 as address.
            cw.ctrl_data = PC_SEL;
            cw.reg_sel   = cpu_pkg::REG_SEL_CONTROL;
            cw.out_plane = cpu_pkg::OUT_REG;
            cw.in_plane  = cpu_pkg::IN_TMP0;
          end
          5'd1: begin                             // Instruction word to opword.
            cw.out_plane = cpu_pkg::OUT_MMU;
            cw.in_plane  = cpu_pkg::IN_OPWORD;
          end
          5'd2: begin                             // Increment of 4 into TMP1.
            cw.ctrl_data = 6'd4;
            cw.out_plane = cpu_pkg::OUT_CTRL_DATA;
            cw.in_plane  = cpu_pkg::IN_TMP1;
          end
          5'd3: begin                             // PC += 4.
            cw.ctrl_data = PC_SEL;
            cw.reg_sel   = cpu_pkg::REG_SEL_CONTROL;
            cw.out_plane = cpu_pkg::OUT_MLU;
            cw.in_plane  = cpu_pkg::IN_REG;
          end
          default: begin                          // Dispatch on the opword opcode.
            cw.in_plane     = cpu_pkg::IN_OPCODE;
            cw.reset_ucount = 1'b1;
          end
        endcase
      end
      cpu_pkg::OP_LH: begin
        case (ucount)
          5'd0: begin                             // Immediate to TMP0.
            cw.out_plane = cpu_pkg::OUT_OPWORD_IMM;
            cw.in_plane  = cpu_pkg::IN_TMP0;
          end
          5'd1: begin                             // Sign extended into rD.
            cw.out_plane     = cpu_pkg::OUT_SHIFTER;
            cw.shifter_plane = cpu_pkg::SHIFT_SIGNEXT16;
            cw.in_plane      = cpu_pkg::IN_REG;
          end
          default: go_fetch = 1'b1;
        endcase
      end
      cpu_pkg::OP_LHU: begin
        if (ucount == 5'd0) begin                 // Zero extended straight into rD.
          cw.out_plane = cpu_pkg::OUT_OPWORD_IMM;
          cw.in_plane  = cpu_pkg::IN_REG;
        end else begin
          go_fetch = 1'b1;
        end
      end
      cpu_pkg::OP_SW, cpu_pkg::OP_LW: begin       // Offset is ignored.
        case (ucount)
          5'd0: begin                             // Address register to TMP0.
            cw.reg_sel   = (opcode == cpu_pkg::OP_SW) ? cpu_pkg::REG_SEL_OPWORD0
                                                      : cpu_pkg::REG_SEL_OPWORD1;
            cw.out_plane = cpu_pkg::OUT_REG;
            cw.in_plane  = cpu_pkg::IN_TMP0;
          end
          5'd1: begin
            if (opcode == cpu_pkg::OP_SW) begin   // rS to memory.
              cw.reg_sel   = cpu_pkg::REG_SEL_OPWORD1;
              cw.out_plane = cpu_pkg::OUT_REG;
              cw.in_plane  = cpu_pkg::IN_MMU;
            end else begin                        // Memory to rD.
              cw.out_plane = cpu_pkg::OUT_MMU;
              cw.in_plane  = cpu_pkg::IN_REG;
            end
          end
          default: go_fetch = 1'b1;
        endcase
      end
      cpu_pkg::OP_ADDU, cpu_pkg::OP_ADD3, cpu_pkg::OP_OR3: begin
        case (ucount)
          5'd0: begin                             // rA to TMP0.
            cw.reg_sel   = cpu_pkg::REG_SEL_OPWORD1;
            cw.out_plane = cpu_pkg::OUT_REG;
            cw.in_plane  = cpu_pkg::IN_TMP0;
          end
          5'd1: begin                             // rB or immediate to TMP1.
            cw.reg_sel   = cpu_pkg::REG_SEL_OPWORD2;
            cw.out_plane = (opcode == cpu_pkg::OP_ADDU) ? cpu_pkg::OUT_OPWORD_IMM
                                                        : cpu_pkg::OUT_REG;
            cw.in_plane  = cpu_pkg::IN_TMP1;
          end
          5'd2: begin                             // Result into rD.
            cw.out_plane = cpu_pkg::OUT_MLU;
            cw.in_plane  = cpu_pkg::IN_REG;
            cw.mlu_op    = (opcode == cpu_pkg::OP_OR3) ? cpu_pkg::MLU_OR : cpu_pkg::MLU_ADD;
          end
          default: go_fetch = 1'b1;
        endcase
      end
      cpu_pkg::OP_BEQ: begin
        case (ucount)
          5'd0: begin                             // rA to TMP0.
            cw.out_plane = cpu_pkg::OUT_REG;
            cw.in_plane  = cpu_pkg::IN_TMP0;
          end
          5'd1: begin                             // rB to TMP1.
            cw.reg_sel   = cpu_pkg::REG_SEL_OPWORD1;
            cw.out_plane = cpu_pkg::OUT_REG;
            cw.in_plane  = cpu_pkg::IN_TMP1;
          end
          5'd2: begin                             // Compare, zero flag latched.
            cw.mlu_op    = cpu_pkg::MLU_SUB;
            cw.mlu_carry = 1'b1;
            cw.cond_sel  = cpu_pkg::COND_ZERO;
          end
          5'd3: begin
            if (cond) begin                       // Equal, offset to TMP0.
              cw.out_plane = cpu_pkg::OUT_OPWORD_IMM;
              cw.in_plane  = cpu_pkg::IN_TMP0;
            end else begin
              go_fetch = 1'b1;                    // Not taken.
            end
          end
          5'd4: cw.in_plane = cpu_pkg::IN_TMP1;   // Clears TMP1.
          5'd5: begin                             // Sign extended offset to TMP1.
            cw.out_plane     = cpu_pkg::OUT_SHIFTER;
            cw.shifter_plane = cpu_pkg::SHIFT_SIGNEXT16;
            cw.in_plane      = cpu_pkg::IN_TMP1;
          end
          5'd6: begin                             // PC to TMP0.
            cw.ctrl_data = PC_SEL;
            cw.reg_sel   = cpu_pkg::REG_SEL_CONTROL;
            cw.out_plane = cpu_pkg::OUT_REG;
            cw.in_plane  = cpu_pkg::IN_TMP0;
          end
          5'd7: begin                             // PC += offset.
            cw.ctrl_data = PC_SEL;
            cw.reg_sel   = cpu_pkg::REG_SEL_CONTROL;
            cw.out_plane = cpu_pkg::OUT_MLU;
            cw.in_plane  = cpu_pkg::IN_REG;
          end
          default: go_fetch = 1'b1;
        endcase
      end
      default: go_fetch = 1'b1;                   // Undefined opcodes act as no-ops.
    endcase
    if (go_fetch) begin                           // Back to fetch, counter restarts.
      cw.ctrl_data    = cpu_pkg::ctrl_data_t'(cpu_pkg::OP_FETCH);
      cw.out_plane    = cpu_pkg::OUT_CTRL_DATA;
      cw.in_plane     = cpu_pkg::IN_OPCODE;
      cw.reset_ucount = 1'b1;
      cw.opcode_sel   = 1'b1;
    end
  end

  // Memory cannot source and sink the bus in one step.
  always_comb begin
    a_no_mmu_loop: assert final (!(cw.out_plane == cpu_pkg::OUT_MMU &&
                                   cw.in_plane == cpu_pkg::IN_MMU))
      else $error("microcode: MMU drives and loads the bus at uaddr %h", uaddr);
  end

endmodule

`default_nettype wire

//--- logic/mlu.sv
`default_nettype none

`include "cpu_config.svh"

module mlu (
  input  cpu_pkg::mlu_op_t op,
  input  logic             carry_in,
  input  cpu_pkg::word_t   a,
  input  cpu_pkg::word_t   b,
  output cpu_pkg::word_t   result,
  output logic             flag_zero,
  output logic             flag_carry,
  output logic             flag_negative
);

  logic [`CPU_WORD_W:0] sum;  // Extra bit holds the carry.

  always_comb begin
    case (op)
      cpu_pkg::MLU_ADD: sum = {1'b0, a} + {1'b0, b} + carry_in;
      cpu_pkg::MLU_SUB: sum = {1'b0, a} + {1'b0, ~b} + carry_in;  // Two's complement.
      default:          sum = {1'b0, a | b};                       // No carry out.
    endcase
  end

  assign result        = sum[`CPU_WORD_W-1:0];
  assign flag_carry    = sum[`CPU_WORD_W];
  assign flag_zero     = (result == '0);
  assign flag_negative = result[`CPU_WORD_W-1];

endmodule

`default_nettype wire

//--- logic/mmu.sv
`default_nettype none

`include "cpu_config.svh"

module mmu (
  input  logic               clk,
  input  logic               rst_n,
  ctrl_if.dp                 cw,
  input  cpu_pkg::word_t     tmp0,
  input  cpu_pkg::word_t     bus,
  output cpu_pkg::word_t     mem_rdata,
  input  logic               load_we,
  input  cpu_pkg::mem_addr_t load_addr,
  input  cpu_pkg::word_t     load_data,
  output logic               store_we
);

  localparam int IDX_W = $clog2(`CPU_MEM_WORDS);

  cpu_pkg::word_t   mem [`CPU_MEM_WORDS];
  logic [IDX_W-1:0] idx;  // Word index from TMP0.

  assign idx       = tmp0[IDX_W+1:2];
  assign mem_rdata = mem[idx];
  assign store_we  = (cw.in_plane == cpu_pkg::IN_MMU);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      if (load_we) begin                   // Program load.
        mem[load_addr[IDX_W+1:2]] <= load_data;
      end
    end else if (store_we) begin
      mem[idx] <= bus;
    end
  end

  a_store_aligned: assert property (@(posedge clk) disable iff (!rst_n)
      store_we |-> tmp0[1:0] == 2'b00)
    else $error("mmu: unaligned store to %h", tmp0);

  a_load_in_reset: assert property (@(posedge clk)
      load_we |-> (!rst_n && load_addr[1:0] == 2'b00))
    else $error("mmu: load port used out of reset or unaligned");

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`default_nettype none

`include "cpu_config.svh"

module reg_file (
  input  logic           clk,
  input  logic           rst_n,
  ctrl_if.dp             cw,
  input  cpu_pkg::word_t opword,
  input  cpu_pkg::word_t bus,
  output cpu_pkg::word_t reg_rdata
);

  cpu_pkg::word_t    regs [`CPU_NUM_REGS];
  cpu_pkg::reg_idx_t idx;  // Shared by read and write.

  always_comb begin
    case (cw.reg_sel)
      cpu_pkg::REG_SEL_OPWORD0: idx = opword[25:21];
      cpu_pkg::REG_SEL_OPWORD1: idx = opword[20:16];
      cpu_pkg::REG_SEL_OPWORD2: idx = opword[15:11];
      default:                  idx = cw.ctrl_data[`CPU_REG_IDX_W-1:0];  // Literal.
    endcase
  end

  assign reg_rdata = regs[idx];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (cw.in_plane == cpu_pkg::IN_REG) begin
      regs[idx] <= bus;
    end
  end

endmodule

`default_nettype wire

//--- tb/cpu_tb.sv
`default_nettype none

`include "cpu_config.svh"

module cpu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PROG_WORDS    = 16;   // One word per reset cycle.
  localparam int RESET_CYCLES  = 16;
  localparam int MAX_STEPS     = 64;   // Model steps before giving up.
  localparam int STORE_TIMEOUT = 200;  // Cycles allowed between stores.
  localparam int QUIET_CYCLES  = 200;  // Store-free window at the end.

  typedef struct packed {
    cpu_pkg::mem_addr_t addr;
    cpu_pkg::word_t     data;
  } store_t;

  logic               clk;
  logic               rst_n;
  logic               load_we;
  cpu_pkg::mem_addr_t load_addr;
  cpu_pkg::word_t     load_data;
  logic               store_we;
  cpu_pkg::mem_addr_t store_addr;
  cpu_pkg::word_t     store_data;

  logic [31:0]    lfsr;                        // Random source.
  cpu_pkg::word_t prog [PROG_WORDS];
  cpu_pkg::word_t model_regs [`CPU_NUM_REGS];  // ISA view, r31 is PC.
  cpu_pkg::word_t model_mem [`CPU_MEM_WORDS];
  store_t         expected [$];                // Stores in program order.
  int unsigned    errors;

  cpu_top cpu_top_i (
    .clk(clk), .rst_n(rst_n), .load_we(load_we), .load_addr(load_addr),
    .load_data(load_data), .store_we(store_we), .store_addr(store_addr),
    .store_data(store_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;                     // 10 ns period.
  end

  task automatic fail_run(string why);
    errors++;
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_addr(string name, cpu_pkg::mem_addr_t got, cpu_pkg::mem_addr_t exp);
    if (got !== exp) begin
      fail_run($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_word(string name, cpu_pkg::word_t got, cpu_pkg::word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
    end
  endtask

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1.
  endfunction

  function automatic logic [31:0] take_bits(int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);                  // One step per bit.
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic cpu_pkg::word_t encode_instr(cpu_pkg::opcode_t op,
      cpu_pkg::reg_idx_t f0, cpu_pkg::reg_idx_t f1, logic [15:0] imm);
    return {op, f0, f1, imm};
  endfunction

  // Sixteen words, so results are stored sparingly and some are seen through others.
  task automatic build_program();
    logic [15:0] i1;
    logic [15:0] i2;
    logic [15:0] i3;
    logic [15:0] i5;
    logic [15:0] off_nt;
    logic [15:0] off_t;
    i1     = {1'b1, 5'(take_bits(5)), 2'b11, 6'(take_bits(6)), 2'b00};  // Aligned, high.
    i2     = {1'b1, 15'(take_bits(15))};      // Negative for LH.
    i3     = {1'b0, 15'(take_bits(15))};      // Positive for LH.
    i5     = 16'(take_bits(16));
    off_nt = take_bits(1) ? 16'd8 : 16'd4;
    off_t  = take_bits(1) ? 16'd8 : 16'd4;    // Skips one or two words.
    prog[0]  = encode_instr(cpu_pkg::OP_LW, 5'd7, 5'd0, 16'h0);    // Reads word 0.
    prog[1]  = encode_instr(cpu_pkg::OP_LHU, 5'd1, 5'd0, i1);
    prog[2]  = encode_instr(cpu_pkg::OP_LH, 5'd2, 5'd0, i2);
    prog[3]  = encode_instr(cpu_pkg::OP_LH, 5'd3, 5'd0, i3);
    prog[4]  = encode_instr(cpu_pkg::OP_ADD3, 5'd4, 5'd1, {5'd2, 11'd0});  // Wraps.
    prog[5]  = encode_instr(cpu_pkg::OP_ADDU, 5'd5, 5'd2, i5);
    prog[6]  = encode_instr(cpu_pkg::OP_OR3, 5'd6, 5'd3, {5'd5, 11'd0});
    prog[7]  = encode_instr(cpu_pkg::OP_SW, 5'd1, 5'd7, 16'h0);   // LW value, far away.
    prog[8]  = encode_instr(cpu_pkg::OP_SW, 5'd0, 5'd2, 16'h0);
    prog[9]  = encode_instr(cpu_pkg::OP_BEQ, 5'd2, 5'd3, off_nt); // Signs differ.
    prog[10] = encode_instr(cpu_pkg::OP_SW, 5'd0, 5'd4, 16'h0);
    prog[11] = encode_instr(cpu_pkg::OP_SW, 5'd0, 5'd6, 16'h0);
    prog[12] = encode_instr(cpu_pkg::OP_BEQ, 5'd5, 5'd5, off_t);
    prog[13] = encode_instr(cpu_pkg::OP_SW, 5'd0, 5'd3, 16'h0);   // Always skipped.
    prog[14] = encode_instr(cpu_pkg::OP_SW, 5'd0, 5'd5, 16'h0);   // Reached on +4.
    prog[15] = encode_instr(cpu_pkg::OP_BEQ, 5'd0, 5'd0, 16'hfffc);  // Self-loop.
  endtask

  // Runs one instruction on the model, returns 1 with the store it makes.
  function automatic logic model_execute(output store_t st);
    cpu_pkg::word_t    ir;
    cpu_pkg::word_t    pc;
    cpu_pkg::reg_idx_t f0;
    cpu_pkg::reg_idx_t f1;
    cpu_pkg::reg_idx_t f2;
    cpu_pkg::word_t    imm_z;
    cpu_pkg::word_t    imm_s;
    logic              stores;
    pc     = model_regs[`CPU_REG_PC];
    ir     = model_mem[pc[`CPU_MEM_ADDR_W-1:2]];
    model_regs[`CPU_REG_PC] = pc + 32'd4;      // PC already points past the op.
    f0     = ir[25:21];
    f1     = ir[20:16];
    f2     = ir[15:11];
    imm_z  = {16'h0000, ir[15:0]};
    imm_s  = {{16{ir[15]}}, ir[15:0]};
    stores = 1'b0;
    st     = '0;
    case (cpu_pkg::opcode_t'(ir[31:26]))
      cpu_pkg::OP_LHU:  model_regs[f0] = imm_z;
      cpu_pkg::OP_LH:   model_regs[f0] = imm_s;
      cpu_pkg::OP_LW:   model_regs[f0] = model_mem[model_regs[f1][`CPU_MEM_ADDR_W-1:2]];
      cpu_pkg::OP_ADDU: model_regs[f0] = model_regs[f1] + imm_z;
      cpu_pkg::OP_ADD3: model_regs[f0] = model_regs[f1] + model_regs[f2];
      cpu_pkg::OP_OR3:  model_regs[f0] = model_regs[f1] | model_regs[f2];
      cpu_pkg::OP_SW: begin                    // Offset ignored.
        st.addr = model_regs[f0][`CPU_MEM_ADDR_W-1:0];
        st.data = model_regs[f1];
        model_mem[model_regs[f0][`CPU_MEM_ADDR_W-1:2]] = model_regs[f1];
        stores  = 1'b1;
      end
      cpu_pkg::OP_BEQ: begin
        if (model_regs[f0] == model_regs[f1]) begin
          model_regs[`CPU_REG_PC] = model_regs[`CPU_REG_PC] + imm_s;
        end
      end
      default: ;
    endcase
    return stores;
  endfunction

  task automatic build_expected();
    store_t         st;
    cpu_pkg::word_t pc_before;
    int             steps;
    logic           looped;
    for (int i = 0; i < `CPU_NUM_REGS; i++) begin
      model_regs[i] = '0;                      // Registers clear on reset.
    end
    for (int i = 0; i < `CPU_MEM_WORDS; i++) begin
      model_mem[i] = (i < PROG_WORDS) ? prog[i] : '0;
    end
    steps  = 0;
    looped = 1'b0;
    while (!looped && steps < MAX_STEPS) begin
      pc_before = model_regs[`CPU_REG_PC];
      if (model_execute(st)) begin
        expected.push_back(st);
      end
      looped = (model_regs[`CPU_REG_PC] == pc_before);  // Final self-loop.
      steps++;
    end
    if (!looped) begin
      fail_run("The reference model never reached the final loop.");
    end
  endtask

  initial begin : stimulus
    rst_n     = 1'b0;
    load_we   = 1'b0;
    load_addr = '0;
    load_data = '0;
    errors    = 0;
    lfsr      = 32'hbbea;
    build_program();
    build_expected();
    load_we   = 1'b1;                          // Word 0 goes in at the first edge.
    load_data = prog[0];
    for (int k = 1; k <= RESET_CYCLES; k++) begin
      @(posedge clk);
      #1;
      if (k < PROG_WORDS) begin
        load_addr = cpu_pkg::mem_addr_t'(k * 4);
        load_data = prog[k];
      end else begin
        load_we = 1'b0;
        rst_n   = 1'b1;                        // Release after 16 edges.
      end
    end
  end

  initial begin : compare_stores
    store_t      exp;
    int unsigned wait_cycles;
    int unsigned checked;
    wait_cycles = 0;
    checked     = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      wait_cycles++;
      if (wait_cycles > RESET_CYCLES + 4) begin
        fail_run("Timeout: reset was never released.");
      end
    end
    while (expected.size() > 0) begin
      wait_cycles = 0;
      @(negedge clk);                          // Outputs settled mid-cycle.
      while (store_we !== 1'b1) begin
        wait_cycles++;
        if (wait_cycles > STORE_TIMEOUT) begin
          fail_run($sformatf("Timeout: no store within %0d cycles, %0d still expected.",
                             STORE_TIMEOUT, expected.size()));
        end
        @(negedge clk);
      end
      exp = expected.pop_front();
      check_addr("store_addr", store_addr, exp.addr);
      check_word("store_data", store_data, exp.data);
      checked++;
    end
    for (int i = 0; i < QUIET_CYCLES; i++) begin
      @(negedge clk);
      if (store_we !== 1'b0) begin
        fail_run("A store occurred after the program reached its final loop.");
      end
    end
    $display("Checked %0d stores.", checked);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire
